/* compile.f */
verilog/tcpStreamPkg.sv
verilog/ethHeaderParser.sv
verilog/ipv4HeaderParser.sv
verilog/tcpHeaderParser.sv
verilog/payloadExtractor.sv
verilog/sequenceTracker.sv
verilog/tcpStreamTop.sv
verif/tcpStreamChecker.sv
verif/tcpStreamTb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tcpStreamTb \
	-f compile.f -o tcpStreamSim \
	&& ./obj_dir/tcpStreamSim | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* verif/tcpStreamTb.sv */
`default_nettype none

module tcpStreamTb import tcpStreamPkg::*; ();

	logic       CLOCK;
	logic       reset;
	streamByteT inStream;
	sessionKeyT session;
	logic       outValid;
	byteT       outData;
	logic       outNewPacket;
	logic       gapped;
	logic       frameDone;
	int         errorCount;

	integer seed;

	// fields of the next frame
	macAddrT     frameDstMac;
	logic        frameVlan;
	logic [15:0] frameEtherType;
	byteT        frameProtocol;
	ipAddrT      frameSrcIp;
	ipAddrT      frameDstIp;
	tcpPortT     frameSrcPort;
	tcpPortT     frameDstPort;
	seqNumT      frameSeq;
	byteT        frameFlags;
	int          frameIpOptions;  // in 32 bit words
	int          frameTcpOptions;
	int          frameLength;     // payload bytes
	int          gapPercent;      // chance of idle cycles before a byte

	byteT frameBytes[$];
	byteT payload[$];

	seqNumT modelExpected;
	logic   modelGapped;
	seqNumT streamSeq; // next in-order sequence number on the sender side

	int testNumber;
	int failedTests;
	int timeoutErrors;
	int errorsAtStart;

	tcpStreamTop DUT (
		.CLOCK        (CLOCK),
		.reset        (reset),
		.inStream     (inStream),
		.session      (session),
		.outValid     (outValid),
		.outData      (outData),
		.outNewPacket (outNewPacket),
		.gapped       (gapped)
	);

	tcpStreamChecker checkerUnit (
		.CLOCK        (CLOCK),
		.reset        (reset),
		.outValid     (outValid),
		.outData      (outData),
		.outNewPacket (outNewPacket),
		.gapped       (gapped),
		.frameDone    (frameDone),
		.errorCount   (errorCount)
	);

	initial CLOCK = 1'b0;
	always #50 CLOCK = ~CLOCK;

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// returns whether the frame belongs to the followed session
	function automatic logic predictFrame();
		logic hit;
		hit = frameDstMac == LOCAL_MAC && frameEtherType == 16'h0800 &&
			frameProtocol == 8'h06 &&
			frameSrcIp == session.srcIp && frameDstIp == session.dstIp &&
			frameSrcPort == session.srcPort && frameDstPort == session.dstPort;
		if (hit) begin
			if (frameFlags[1]) begin
				modelExpected = frameSeq + 32'd1; // syn takes one number
			end else begin
				modelGapped = frameSeq != modelExpected;
				modelExpected = frameSeq + seqNumT'(frameLength);
			end
		end
		return hit;
	endfunction

	////////////////////////////////////////////////////////////
	// frame builder and driver
	////////////////////////////////////////////////////////////

	task automatic driveStream(input logic newPacket, input logic valid, input byteT data);
		@(posedge CLOCK);
		#10;
		inStream.newPacket = newPacket;
		inStream.valid = valid;
		inStream.data = data;
	endtask

	task automatic loadDefaultFrame();
		frameDstMac = LOCAL_MAC;
		frameVlan = 1'b0;
		frameEtherType = 16'h0800;
		frameProtocol = 8'h06;
		frameSrcIp = session.srcIp;
		frameDstIp = session.dstIp;
		frameSrcPort = session.srcPort;
		frameDstPort = session.dstPort;
		frameFlags = 8'h18; // psh and ack
		frameIpOptions = 0;
		frameTcpOptions = 0;
		frameLength = 16;
	endtask

	task automatic appendField(input logic [47:0] value, input int count);
		for (int i = count - 1; i >= 0; i--) begin
			frameBytes.push_back(value[8 * i +: 8]); // network order
		end
	endtask

	task automatic buildFrame();
		int   ihl;
		int   offset;
		int   total;
		int   roll;
		byteT value;
		frameBytes.delete();
		payload.delete();
		ihl = 5 + frameIpOptions;
		offset = 5 + frameTcpOptions;
		total = 4 * ihl + 4 * offset + frameLength;
		appendField(frameDstMac, 6);
		appendField(48'h02_00_5e_10_20_30, 6);
		if (frameVlan) begin
			appendField(48'h8100, 2);
			appendField(48'h0064, 2); // vid 100
		end
		appendField(frameEtherType, 2);
		appendField({4'h4, ihl[3:0]}, 1);
		appendField(48'h00, 1);
		appendField(total[15:0], 2);
		appendField(48'h1c46_4000, 4); // id and dont fragment
		appendField(48'h40, 1);
		appendField(frameProtocol, 1);
		appendField(48'h0000, 2);      // checksum not checked
		appendField(frameSrcIp, 4);
		appendField(frameDstIp, 4);
		repeat (4 * frameIpOptions) appendField(48'h01, 1);
		appendField(frameSrcPort, 2);
		appendField(frameDstPort, 2);
		appendField(frameSeq, 4);
		appendField(48'h0, 4);
		appendField({offset[3:0], 4'h0}, 1);
		appendField(frameFlags, 1);
		appendField(48'hffff, 2);
		appendField(48'h0, 4);         // checksum and urgent pointer
		repeat (4 * frameTcpOptions) appendField(48'h01, 1);
		for (int i = 0; i < frameLength; i++) begin
			roll = $random(seed);
			value = roll[7:0];
			payload.push_back(value);
			frameBytes.push_back(value);
		end
	endtask

	task automatic waitForDrain();
		int cycles;
		cycles = 0;
		while (checkerUnit.pendingBytes() != 0 && cycles < 400) begin
			@(posedge CLOCK);
			cycles++;
		end
		if (checkerUnit.pendingBytes() != 0) begin
			$display("timeout at %0t: %0d payload bytes never came out of the DUT",
				$time, checkerUnit.pendingBytes());
			timeoutErrors++;
			checkerUnit.flushExpected();
		end
	endtask

	task automatic sendFrame();
		logic        hit;
		int unsigned roll;
		int unsigned idle;
		buildFrame();
		hit = predictFrame();
		if (hit) begin
			for (int i = 0; i < payload.size(); i++) begin
				checkerUnit.expectByte(i == 0, payload[i]);
			end
		end
		checkerUnit.expectGap(modelGapped);
		driveStream(1'b1, 1'b0, 8'h00);
		foreach (frameBytes[i]) begin
			roll = $random(seed);
			if (roll % 100 < gapPercent) begin
				roll = $random(seed);
				idle = 1 + roll % 3;
				repeat (idle) driveStream(1'b0, 1'b0, 8'h00);
			end
			driveStream(1'b0, 1'b1, frameBytes[i]);
		end
		driveStream(1'b0, 1'b0, 8'h00);
		waitForDrain();
		repeat (2) driveStream(1'b0, 1'b0, 8'h00);
		@(posedge CLOCK);
		#10;
		frameDone = 1'b1;
		@(posedge CLOCK);
		#10;
		frameDone = 1'b0;
	endtask

	task automatic sendData(input int length);
		frameSeq = streamSeq;
		frameLength = length;
		sendFrame();
		streamSeq = streamSeq + seqNumT'(length);
	endtask

	// dropped frames leave the sender sequence where it is
	task automatic sendStray(input int length);
		frameSeq = streamSeq;
		frameLength = length;
		sendFrame();
	endtask

	task automatic sendSyn(input seqNumT seq);
		loadDefaultFrame();
		frameFlags = 8'h02;
		frameSeq = seq;
		frameLength = 0;
		sendFrame();
		streamSeq = seq + 32'd1;
	endtask

	task automatic startTest();
		errorsAtStart = errorCount + timeoutErrors;
		testNumber++;
	endtask

	task automatic finishTest(input string name);
		int errors;
		errors = errorCount + timeoutErrors - errorsAtStart;
		if (errors == 0) begin
			$display("test %0d %s: ok", testNumber, name);
		end else begin
			$display("test %0d %s: %0d errors", testNumber, name, errors);
			failedTests++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		seed = 32'h9692_51dd;
		reset = 1'b1;
		inStream = '0;
		frameDone = 1'b0;
		session.srcIp = 32'h0a01_0203;   // 10.1.2.3
		session.dstIp = 32'hc0a8_0a14;   // 192.168.10.20
		session.srcPort = 16'hc35a;
		session.dstPort = 16'h0050;
		modelExpected = '0;
		modelGapped = 1'b0;
		streamSeq = '0;
		gapPercent = 0;
		testNumber = 0;
		failedTests = 0;
		timeoutErrors = 0;
		loadDefaultFrame();
		repeat (8) @(posedge CLOCK);
		#10;
		reset = 1'b0;

		startTest();
		sendSyn(32'h0000_1000);
		loadDefaultFrame();
		sendData(24);
		loadDefaultFrame();
		sendData(1);
		finishTest("plain segment");

		startTest();
		loadDefaultFrame();
		frameIpOptions = 2;
		frameTcpOptions = 3;
		sendData(40);
		loadDefaultFrame();
		frameIpOptions = 10;
		frameTcpOptions = 10;
		sendData(5);
		finishTest("ip and tcp options");

		startTest();
		loadDefaultFrame();
		frameVlan = 1'b1;
		sendData(30);
		loadDefaultFrame();
		frameVlan = 1'b1;
		frameTcpOptions = 2;
		sendData(12);
		finishTest("vlan tag");

		startTest();
		loadDefaultFrame();
		frameDstMac = LOCAL_MAC ^ 48'h1;
		sendStray(16);
		loadDefaultFrame();
		frameEtherType = 16'h86dd; // ipv6
		sendStray(16);
		loadDefaultFrame();
		frameProtocol = 8'h11;     // udp
		sendStray(16);
		loadDefaultFrame();
		frameSrcIp = session.srcIp ^ 32'h1;
		sendStray(16);
		loadDefaultFrame();
		frameDstIp = session.dstIp ^ 32'h100;
		sendStray(16);
		loadDefaultFrame();
		frameSrcPort = session.srcPort + 16'd1;
		sendStray(16);
		loadDefaultFrame();
		frameDstPort = session.dstPort ^ 16'h8000;
		sendStray(16);
		sendSyn(32'h0002_0000);
		finishTest("filtered frames");

		startTest();
		sendSyn(32'hffff_fff0); // data wraps past zero
		loadDefaultFrame();
		sendData(10);
		loadDefaultFrame();
		sendData(20);
		streamSeq = streamSeq + 32'd100;
		loadDefaultFrame();
		sendData(8);
		loadDefaultFrame();
		sendData(8);
		finishTest("sequence gap");

		startTest();
		gapPercent = 30;
		sendSyn(32'h7000_0000);
		for (int k = 0; k < 6; k++) begin
			loadDefaultFrame();
			frameVlan = k[0];
			frameIpOptions = k % 3;
			frameTcpOptions = k % 4;
			if (k == 3) begin
				streamSeq = streamSeq + 32'd7;
			end
			sendData(1 + {$random(seed)} % 48);
		end
		loadDefaultFrame();
		frameDstPort = session.dstPort + 16'd1;
		sendStray(20);
		gapPercent = 0;
		finishTest("valid gaps");

		$display("%0d tests, %0d failed, %0d errors", testNumber, failedTests,
			errorCount + timeoutErrors);
		if (failedTests == 0 && errorCount + timeoutErrors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/tcpStreamChecker.sv */
`default_nettype none

module tcpStreamChecker import tcpStreamPkg::*; (
	input  wire       CLOCK,
	input  wire       reset,
	input  wire       outValid,
	input  wire byteT outData,
	input  wire       outNewPacket,
	input  wire       gapped,
	input  wire       frameDone,
	output int        errorCount
);

	logic [8:0] expectedBytes[$]; // first flag above the byte
	logic       expectedGaps[$];  // one per frame
	logic [8:0] entry;

	task automatic expectByte(input logic first, input byteT value);
		expectedBytes.push_back({first, value});
	endtask

	task automatic expectGap(input logic value);
		expectedGaps.push_back(value);
	endtask

	function automatic int pendingBytes();
		return expectedBytes.size();
	endfunction

	task automatic flushExpected();
		expectedBytes.delete();
	endtask

	initial errorCount = 0;

	// outputs settle after the rising edge
	always @(negedge CLOCK) begin
		if (!reset) begin
			if (outValid) begin
				if (expectedBytes.size() == 0) begin
					$display("error at %0t: unexpected payload byte %h", $time, outData);
					errorCount++;
				end else begin
					entry = expectedBytes.pop_front();
					if (outData !== entry[7:0]) begin
						$display("error at %0t: payload byte %h, expected %h",
							$time, outData, entry[7:0]);
						errorCount++;
					end
					if (outNewPacket !== entry[8]) begin
						$display("error at %0t: outNewPacket %b, expected %b",
							$time, outNewPacket, entry[8]);
						errorCount++;
					end
				end
			end else if (outNewPacket) begin
				$display("error at %0t: outNewPacket without outValid", $time);
				errorCount++;
			end
			if (outNewPacket && expectedGaps.size() != 0 && gapped !== expectedGaps[0]) begin
				$display("error at %0t: gapped %b at first byte, expected %b",
					$time, gapped, expectedGaps[0]);
				errorCount++;
			end
			if (frameDone) begin
				if (expectedGaps.size() == 0) begin
					$display("checker saw a frame end with no expected gap flag queued");
					errorCount++;
				end else begin
					if (gapped !== expectedGaps[0]) begin
						$display("error at %0t: gapped %b at frame end, expected %b",
							$time, gapped, expectedGaps[0]);
						errorCount++;
					end
					void'(expectedGaps.pop_front());
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/tcpStreamTop.sv */
`default_nettype none

module tcpStreamTop import tcpStreamPkg::*; (
	input  wire         CLOCK,
	input  wire         reset,
	input  wire streamByteT inStream,
	input  wire sessionKeyT session,
	output logic        outValid,
	output byteT        outData,
	output logic        outNewPacket,
	output logic        gapped
);

	logic        ipv4Start;
	logic        tcpStart;
	logic        ipMatch;
	lengthT      segmentLength;
	logic        segmentReady;
	segmentInfoT segmentInfo;

	////////////////////////////////////////////////////////////
	// layer parsers, all on the same byte stream
	////////////////////////////////////////////////////////////

	ethHeaderParser ethParser (
		.CLOCK     (CLOCK),
		.reset     (reset),
		.inStream  (inStream),
		.ipv4Start (ipv4Start)
	);

	ipv4HeaderParser ipv4Parser (
		.CLOCK         (CLOCK),
		.reset         (reset),
		.inStream      (inStream),
		.ipv4Start     (ipv4Start),
		.session       (session),
		.tcpStart      (tcpStart),
		.ipMatch       (ipMatch),
		.segmentLength (segmentLength)
	);

	tcpHeaderParser tcpParser (
		.CLOCK         (CLOCK),
		.reset         (reset),
		.inStream      (inStream),
		.tcpStart      (tcpStart),
		.ipMatch       (ipMatch),
		.session       (session),
		.segmentLength (segmentLength),
		.segmentReady  (segmentReady),
		.segmentInfo   (segmentInfo)
	);

	////////////////////////////////////////////////////////////
	// segment consumers
	////////////////////////////////////////////////////////////

	payloadExtractor extractor (
		.CLOCK        (CLOCK),
		.reset        (reset),
		.inStream     (inStream),
		.segmentReady (segmentReady),
		.segmentInfo  (segmentInfo),
		.outValid     (outValid),
		.outData      (outData),
		.outNewPacket (outNewPacket)
	);

	sequenceTracker tracker (
		.CLOCK        (CLOCK),
		.reset        (reset),
		.segmentReady (segmentReady),
		.segmentInfo  (segmentInfo),
		.gapped       (gapped)
	);

endmodule

`default_nettype wire

/* verilog/sequenceTracker.sv */
`default_nettype none

module sequenceTracker import tcpStreamPkg::*; (
	input  wire         CLOCK,
	input  wire         reset,
	input  wire         segmentReady,
	input  wire segmentInfoT segmentInfo,
	output logic        gapped
);

	seqNumT expected; // next in-order sequence number
	logic   tracked;

	// only segments of the followed session count
	assign tracked = segmentReady && segmentInfo.sessionMatch;

	always_ff @(posedge CLOCK) begin
		if (reset) begin
			expected <= '0;
			gapped <= 1'b0;
		end else if (tracked) begin
			if (segmentInfo.syn) begin
				// syn consumes one sequence number
				expected <= segmentInfo.seq + 1'b1;
			end else begin
				gapped <= segmentInfo.seq != expected;
				expected <= segmentInfo.seq + seqNumT'(segmentInfo.payloadLength); // resync
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/payloadExtractor.sv */
`default_nettype none

module payloadExtractor import tcpStreamPkg::*; (
	input  wire         CLOCK,
	input  wire         reset,
	input  wire streamByteT inStream,
	input  wire         segmentReady,
	input  wire segmentInfoT segmentInfo,
	output logic        outValid,
	output byteT        outData,
	output logic        outNewPacket
);

	lengthT remaining;
	lengthT countNow;
	logic   active;
	logic   firstPending;
	logic   startNow;
	logic   takeByte;

	// first payload byte may share the cycle with segmentReady
	assign startNow = segmentReady && segmentInfo.sessionMatch && segmentInfo.payloadLength != '0;
	assign countNow = startNow ? segmentInfo.payloadLength : remaining;
	assign takeByte = (startNow || active) && inStream.valid && !inStream.newPacket;

	always_ff @(posedge CLOCK) begin
		if (reset) begin
			remaining <= '0;
			active <= 1'b0;
			firstPending <= 1'b0;
			outValid <= 1'b0;
			outNewPacket <= 1'b0;
		end else begin
			outValid <= takeByte;
			outNewPacket <= takeByte && (startNow || firstPending);
			if (inStream.newPacket) begin
				active <= 1'b0; // abort a cut short payload
				firstPending <= 1'b0;
			end else if (takeByte) begin
				remaining <= countNow - 1'b1;
				active <= countNow != 16'd1;
				firstPending <= 1'b0;
			end else if (startNow) begin
				remaining <= countNow;
				active <= 1'b1;
				firstPending <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLOCK) begin
		if (takeByte) begin
			outData <= inStream.data;
		end
	end

	firstByteValid: assert property (@(posedge CLOCK) disable iff (reset)
		outNewPacket |-> outValid);

endmodule

`default_nettype wire

/* verilog/tcpHeaderParser.sv */
`default_nettype none

module tcpHeaderParser import tcpStreamPkg::*; (
	input  wire         CLOCK,
	input  wire         reset,
	input  wire streamByteT inStream,
	input  wire         tcpStart,
	input  wire         ipMatch,
	input  wire sessionKeyT session,
	input  wire lengthT segmentLength,
	output logic        segmentReady,
	output segmentInfoT segmentInfo
);

	tcpStateT   state;
	tcpStateT   curState;
	logic [4:0] byteCount;
	logic [4:0] curCount;
	logic [5:0] optionBytes;
	logic [3:0] dataOffset;
	seqNumT     seqBuffer;
	logic       synFlag;
	logic       ipHit;
	logic       portMatch;
	logic       portByteOk;
	logic       lastByte;
	lengthT     headerBytes;

	always_comb begin
		curState = state;
		curCount = byteCount;
		if (tcpStart) begin // byte 0 can come with the pulse
			curState = TCP_HEADER;
			curCount = '0;
		end
	end

	// ports sit in the first four bytes
	always_comb begin
		portByteOk = 1'b1;
		if (curState == TCP_HEADER && curCount <= 5'd1) begin
			portByteOk = inStream.data == session.srcPort[8 * (1 - curCount) +: 8];
		end else if (curState == TCP_HEADER && curCount <= 5'd3) begin
			portByteOk = inStream.data == session.dstPort[8 * (3 - curCount) +: 8];
		end
	end

	assign headerBytes = lengthT'({dataOffset, 2'b00});
	assign lastByte = inStream.valid && !inStream.newPacket &&
		((curState == TCP_HEADER && curCount == HEADER_LAST_BYTE &&
			dataOffset == TCP_MIN_HEADER_WORDS) ||
		(curState == TCP_OPTIONS && optionBytes == 6'd1));

	always_ff @(posedge CLOCK) begin
		if (reset) begin
			state <= TCP_IDLE;
			byteCount <= '0;
			optionBytes <= '0;
			ipHit <= 1'b0;
			portMatch <= 1'b0;
			segmentReady <= 1'b0;
		end else begin
			segmentReady <= 1'b0;
			if (inStream.newPacket) begin
				state <= TCP_IDLE;
			end else begin
				state <= curState;
				byteCount <= curCount;
				if (tcpStart) begin
					ipHit <= ipMatch; // ipMatch is a pulse so hold it for the segment
				end
				if (inStream.valid) begin
					case (curState)
						TCP_HEADER: begin
							byteCount <= curCount + 1'b1;
							portMatch <= (curCount == 5'd0) ? portByteOk : portMatch & portByteOk;
							if (curCount == 5'd12 && inStream.data[7:4] < TCP_MIN_HEADER_WORDS) begin
								state <= TCP_IDLE; // bad data offset
							end
							if (curCount == HEADER_LAST_BYTE) begin
								state <= TCP_OPTIONS;
								optionBytes <= {dataOffset - TCP_MIN_HEADER_WORDS, 2'b00};
							end
						end
						TCP_OPTIONS: optionBytes <= optionBytes - 1'b1;
						default: ;
					endcase
					if (lastByte) begin
						state <= TCP_IDLE;
						segmentReady <= 1'b1;
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// header fields and segment summary
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK) begin
		if (inStream.valid && !inStream.newPacket && curState == TCP_HEADER) begin
			if (curCount >= 5'd4 && curCount <= 5'd7) begin
				seqBuffer <= {seqBuffer[23:0], inStream.data}; // network order
			end
			if (curCount == 5'd12) begin
				dataOffset <= inStream.data[7:4];
			end
			if (curCount == 5'd13) begin
				synFlag <= inStream.data[1];
			end
		end
		if (lastByte) begin
			segmentInfo.seq <= seqBuffer;
			segmentInfo.syn <= synFlag;
			segmentInfo.sessionMatch <= ipHit & portMatch;
			// a short ip length leaves no payload
			segmentInfo.payloadLength <= (segmentLength > headerBytes) ?
				segmentLength - headerBytes : '0;
		end
	end

endmodule

`default_nettype wire

/* verilog/ipv4HeaderParser.sv */
`default_nettype none

module ipv4HeaderParser import tcpStreamPkg::*; (
	input  wire        CLOCK,
	input  wire        reset,
	input  wire streamByteT inStream,
	input  wire        ipv4Start,
	input  wire sessionKeyT session,
	output logic       tcpStart,
	output logic       ipMatch,
	output lengthT     segmentLength
);

	ipv4StateT  state;
	ipv4StateT  curState;
	logic [4:0] byteCount;
	logic [4:0] curCount;
	logic [5:0] optionBytes;
	logic [3:0] headerWords;
	lengthT     totalLength;
	byteT       protocol;
	logic       addrMatch;
	logic       addrByteOk;
	logic       lastByte;
	logic       isTcp;

	// first header byte may arrive together with the start pulse
	always_comb begin
		curState = state;
		curCount = byteCount;
		if (ipv4Start) begin
			curState = IPV4_HEADER;
			curCount = '0;
		end
	end

	// source address at bytes 12..15, destination at 16..19
	always_comb begin
		addrByteOk = 1'b1;
		if (curState == IPV4_HEADER && curCount >= 5'd12 && curCount <= 5'd15) begin
			addrByteOk = inStream.data == session.srcIp[8 * (15 - curCount) +: 8];
		end else if (curState == IPV4_HEADER && curCount >= 5'd16) begin
			addrByteOk = inStream.data == session.dstIp[8 * (19 - curCount) +: 8];
		end
	end

	assign isTcp = protocol == IP_PROTOCOL_TCP;
	assign lastByte = inStream.valid && !inStream.newPacket &&
		((curState == IPV4_HEADER && curCount == HEADER_LAST_BYTE &&
			headerWords == IPV4_MIN_HEADER_WORDS) ||
		(curState == IPV4_OPTIONS && optionBytes == 6'd1));

	always_ff @(posedge CLOCK) begin
		if (reset) begin
			state <= IPV4_IDLE;
			byteCount <= '0;
			optionBytes <= '0;
			addrMatch <= 1'b0;
			tcpStart <= 1'b0;
			ipMatch <= 1'b0;
		end else begin
			tcpStart <= 1'b0;
			ipMatch <= 1'b0;
			if (inStream.newPacket) begin
				state <= IPV4_IDLE;
			end else begin
				state <= curState;
				byteCount <= curCount;
				if (inStream.valid) begin
					case (curState)
						IPV4_HEADER: begin
							byteCount <= curCount + 1'b1;
							addrMatch <= (curCount == 5'd0) ? 1'b1 : addrMatch & addrByteOk;
							if (curCount == 5'd0 && inStream.data[3:0] < IPV4_MIN_HEADER_WORDS) begin
								state <= IPV4_IDLE; // bad ihl
							end
							if (curCount == HEADER_LAST_BYTE) begin
								state <= IPV4_OPTIONS;
								optionBytes <= {headerWords - IPV4_MIN_HEADER_WORDS, 2'b00};
							end
						end
						IPV4_OPTIONS: optionBytes <= optionBytes - 1'b1; // skipped
						default: ;
					endcase
					if (lastByte) begin
						state <= IPV4_IDLE;
						tcpStart <= isTcp;
						ipMatch <= isTcp && addrMatch && addrByteOk;
					end
				end
			end
		end
	end

	// header fields
	always_ff @(posedge CLOCK) begin
		if (inStream.valid && !inStream.newPacket && curState == IPV4_HEADER) begin
			case (curCount)
				5'd0: headerWords <= inStream.data[3:0];
				5'd2: totalLength[15:8] <= inStream.data;
				5'd3: totalLength[7:0] <= inStream.data;
				5'd9: protocol <= inStream.data;
				default: ;
			endcase
		end
		if (lastByte && isTcp) begin
			segmentLength <= totalLength - lengthT'({headerWords, 2'b00});
		end
	end

	// ihl was checked long before the header ends
	headerLengthValid: assert property (@(posedge CLOCK) disable iff (reset)
		tcpStart |-> headerWords >= IPV4_MIN_HEADER_WORDS);

endmodule

`default_nettype wire

/* verilog/ethHeaderParser.sv */
`default_nettype none

module ethHeaderParser import tcpStreamPkg::*; (
	input  wire        CLOCK,
	input  wire        reset,
	input  wire streamByteT inStream,
	output logic       ipv4Start
);

	ethStateT   state;
	logic [2:0] byteCount;
	logic       macMatch;
	logic       macByteOk;
	logic       vlanSeen;
	byteT       typeHigh;
	logic [15:0] etherType;

	assign macByteOk = inStream.data == LOCAL_MAC[8 * (5 - byteCount) +: 8]; // msb first
	assign etherType = {typeHigh, inStream.data};

	always_ff @(posedge CLOCK) begin
		if (reset) begin
			state <= ETH_IDLE;
			byteCount <= '0;
			macMatch <= 1'b0;
			vlanSeen <= 1'b0;
			ipv4Start <= 1'b0;
		end else begin
			ipv4Start <= 1'b0;
			if (inStream.newPacket) begin
				state <= ETH_DST_MAC;
				byteCount <= '0;
				macMatch <= 1'b1;
				vlanSeen <= 1'b0;
			end else if (inStream.valid) begin
				case (state)
					ETH_DST_MAC: begin
						byteCount <= byteCount + 1'b1;
						macMatch <= macMatch & macByteOk;
						if (byteCount == 3'd5) begin
							byteCount <= '0;
							// drop frames addressed elsewhere
							state <= (macMatch & macByteOk) ? ETH_SRC_MAC : ETH_IDLE;
						end
					end
					ETH_SRC_MAC: begin
						byteCount <= byteCount + 1'b1;
						if (byteCount == 3'd5) begin
							byteCount <= '0;
							state <= ETH_TYPE_HI;
						end
					end
					ETH_TYPE_HI: state <= ETH_TYPE_LO;
					ETH_TYPE_LO: begin
						if (etherType == ETHERTYPE_VLAN && !vlanSeen) begin
							state <= ETH_VLAN_TAG; // one tag only
							vlanSeen <= 1'b1;
						end else begin
							state <= ETH_IDLE;
							ipv4Start <= etherType == ETHERTYPE_IPV4;
						end
					end
					ETH_VLAN_TAG: begin
						byteCount <= byteCount + 1'b1;
						if (byteCount == 3'd1) begin // tci is two bytes
							byteCount <= '0;
							state <= ETH_TYPE_HI;
						end
					end
					default: state <= ETH_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge CLOCK) begin
		if (inStream.valid && !inStream.newPacket && state == ETH_TYPE_HI) begin
			typeHigh <= inStream.data;
		end
	end

	// the ipv4 stage must see exactly one start per frame
	ipv4StartSingle: assert property (@(posedge CLOCK) disable iff (reset)
		ipv4Start |=> !ipv4Start);

endmodule

`default_nettype wire

/* verilog/tcpStreamPkg.sv */
`default_nettype none

package tcpStreamPkg;

	////////////////////////////////////////////////////////////
	// vector types
	////////////////////////////////////////////////////////////

	typedef logic [7:0]  byteT;
	typedef logic [31:0] ipAddrT;
	typedef logic [15:0] tcpPortT;
	typedef logic [31:0] seqNumT;
	typedef logic [15:0] lengthT;
	typedef logic [47:0] macAddrT;

	////////////////////////////////////////////////////////////
	// protocol constants
	////////////////////////////////////////////////////////////

	localparam macAddrT LOCAL_MAC = 48'h02_1a_4b_00_7e_c3; // locally administered

	localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
	localparam logic [15:0] ETHERTYPE_VLAN = 16'h8100; // 802.1Q tag protocol id

	localparam byteT IP_PROTOCOL_TCP = 8'h06;

	// both headers are 5 words without options
	localparam logic [3:0] IPV4_MIN_HEADER_WORDS = 4'd5;
	localparam logic [3:0] TCP_MIN_HEADER_WORDS = 4'd5;

	// index of the last byte of a 20 byte fixed header
	localparam logic [4:0] HEADER_LAST_BYTE = 5'd19;

	////////////////////////////////////////////////////////////
	// structs
	////////////////////////////////////////////////////////////

	// the newPacket cycle marks a frame start and carries no byte
	typedef struct packed {
		logic newPacket;
		logic valid;
		byteT data;
	} streamByteT;

	// four-tuple as seen in the followed direction
	typedef struct packed {
		ipAddrT  srcIp;
		ipAddrT  dstIp;
		tcpPortT srcPort;
		tcpPortT dstPort;
	} sessionKeyT;

	typedef struct packed {
		seqNumT seq;
		logic   syn;
		logic   sessionMatch;  // ip and port tuple all hit
		lengthT payloadLength; // bytes after the tcp header
	} segmentInfoT;

	////////////////////////////////////////////////////////////
	// parser states
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		ETH_IDLE,
		ETH_DST_MAC,
		ETH_SRC_MAC,
		ETH_TYPE_HI,
		ETH_TYPE_LO,
		ETH_VLAN_TAG
	} ethStateT;

	typedef enum logic [1:0] {
		IPV4_IDLE,
		IPV4_HEADER,
		IPV4_OPTIONS
	} ipv4StateT;

	typedef enum logic [1:0] {
		TCP_IDLE,
		TCP_HEADER,
		TCP_OPTIONS
	} tcpStateT;

endpackage

`default_nettype wire
